/* hw/sampler_pkg.sv */
// --------------------------------------------------------------------------
// widths, constants and types shared by the sampler units
// q values are for ML-DSA and ML-KEM only, one job is always 256 coefficients
// --------------------------------------------------------------------------

package sampler_pkg;

  // stream and buffer
  localparam int unsigned WORD_W      = 64;
  localparam int unsigned PISO_BUF_W  = 160;
  localparam int unsigned REJ_SLICE_W = 96;
  localparam int unsigned EXP_SLICE_W = 80;
  localparam int unsigned PISO_FILL_W = $clog2(PISO_BUF_W + 1);

  // coefficients and job size
  localparam int unsigned COEFF_W       = 23;
  localparam int unsigned COEFF_PER_CLK = 4;
  localparam int unsigned COEFF_CNT     = 256;
  localparam int unsigned GROUP_CNT     = COEFF_CNT / COEFF_PER_CLK;
  localparam int unsigned GROUP_CNT_W   = $clog2(GROUP_CNT);
  localparam int unsigned ADDR_W        = 14;

  // rejection sampling
  localparam int unsigned MLDSA_Q         = 8380417;
  localparam int unsigned MLKEM_Q         = 3329;
  localparam int unsigned MLDSA_CAND_W    = 24;
  localparam int unsigned MLKEM_CAND_W    = 12;
  localparam int unsigned MLDSA_CAND_CNT  = REJ_SLICE_W / MLDSA_CAND_W;
  localparam int unsigned MLKEM_CAND_CNT  = REJ_SLICE_W / MLKEM_CAND_W;
  localparam int unsigned REJ_QUEUE_DEPTH = 12;
  localparam int unsigned REJ_CNT_W       = $clog2(REJ_QUEUE_DEPTH + 1);

  // mask expansion
  localparam int unsigned EXP_SAMPLE_W = 20;
  localparam int unsigned EXP_GAMMA1   = 1 << 19;

  typedef enum logic [1:0] {
    MODE_MLDSA_REJ = 2'd0,
    MODE_MLKEM_REJ = 2'd1,
    MODE_EXP_MASK  = 2'd2
  } sampler_mode_e;

  typedef enum logic {
    CTRL_IDLE = 1'b0,
    CTRL_RUN  = 1'b1
  } ctrl_state_e;

  // lane 0 holds the oldest coefficient
  typedef logic [COEFF_PER_CLK-1:0][COEFF_W-1:0] coeff_group_t;

endpackage

/* hw/sampler_ctrl.sv */
// --------------------------------------------------------------------------
// job controller, a start while a job runs is ignored
// flush ends a job on the 64th output strobe or on zeroize
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module sampler_ctrl (
  input  logic                           clk,
  input  logic                           rst_b,
  input  logic                           zeroize_i,
  input  logic                           start_i,
  input  logic [sampler_pkg::ADDR_W-1:0] dest_base_addr_i,
  input  logic                           ntt_dv_i,
  input  logic                           mem_dv_i,
  output logic                           run_o,
  output logic                           flush_o,
  output logic                           busy_o,
  output logic [sampler_pkg::ADDR_W-1:0] mem_addr_o
);

  import sampler_pkg::*;

  ctrl_state_e            state_q;
  ctrl_state_e            state_d;
  logic [GROUP_CNT_W-1:0] group_cnt_q;
  logic                   strobe;
  logic                   start_job;

  assign strobe    = ntt_dv_i || mem_dv_i;
  assign start_job = start_i && (state_q == CTRL_IDLE);
  assign run_o     = (state_q == CTRL_RUN);
  assign busy_o    = start_i || run_o;

  // last group of the job, or zeroize
  assign flush_o = zeroize_i ||
                   (strobe && (group_cnt_q == GROUP_CNT_W'(GROUP_CNT - 1)));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CTRL_IDLE: begin
        if (start_i && !flush_o) begin
          state_d = CTRL_RUN;
        end
      end
      CTRL_RUN: begin
        if (flush_o) begin
          state_d = CTRL_IDLE;
        end
      end
      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q     <= CTRL_IDLE;
      group_cnt_q <= '0;
      mem_addr_o  <= '0;
    end else begin
      state_q <= state_d;
      if (flush_o) begin
        group_cnt_q <= '0;
      end else if (start_job) begin
        group_cnt_q <= '0;
        mem_addr_o  <= dest_base_addr_i;
      end else begin
        if (strobe) begin
          group_cnt_q <= group_cnt_q + 1'b1;
        end
        // next memory row
        if (mem_dv_i) begin
          mem_addr_o <= mem_addr_o + 1'b1;
        end
      end
    end
  end

endmodule

/* hw/sample_piso.sv */
// --------------------------------------------------------------------------
// bit buffer, words are appended LSB-first above the current fill
// slices are 96 bits in the rejection modes and 80 bits in mask mode
// hold_i is ignored in mask mode since that sampler takes every slice
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module sample_piso (
  input  logic                                clk,
  input  logic                                rst_b,
  input  sampler_pkg::sampler_mode_e          mode_i,
  input  logic                                run_i,
  input  logic                                flush_i,
  input  logic                                word_valid_i,
  input  logic [sampler_pkg::WORD_W-1:0]      word_data_i,
  input  logic                                hold_i,
  output logic                                word_hold_o,
  output logic                                slice_valid_o,
  output logic [sampler_pkg::REJ_SLICE_W-1:0] slice_data_o
);

  import sampler_pkg::*;

  logic [PISO_BUF_W-1:0]  bit_buf_q;
  logic [PISO_BUF_W-1:0]  bit_buf_d;
  logic [PISO_BUF_W-1:0]  buf_kept;
  logic [PISO_FILL_W-1:0] fill_q;
  logic [PISO_FILL_W-1:0] fill_d;
  logic [PISO_FILL_W-1:0] fill_kept;
  logic [PISO_FILL_W-1:0] slice_w;
  logic                   word_take;
  logic                   slice_take;

  assign slice_w = (mode_i == MODE_EXP_MASK) ? PISO_FILL_W'(EXP_SLICE_W) :
                                               PISO_FILL_W'(REJ_SLICE_W);

  assign slice_valid_o = (fill_q >= slice_w);
  assign slice_data_o  = bit_buf_q[REJ_SLICE_W-1:0];

  // room for one more word only while fill is at most 96
  assign word_hold_o = !run_i || (fill_q > PISO_FILL_W'(PISO_BUF_W - WORD_W));
  assign word_take   = word_valid_i && !word_hold_o;
  assign slice_take  = slice_valid_o && ((mode_i == MODE_EXP_MASK) || !hold_i);

  always_comb begin
    buf_kept  = bit_buf_q;
    fill_kept = fill_q;
    if (slice_take) begin
      buf_kept  = bit_buf_q >> slice_w;
      fill_kept = fill_q - slice_w;
    end
    bit_buf_d = buf_kept;
    fill_d    = fill_kept;
    // bits above the fill are always zero, so an OR appends
    if (word_take) begin
      bit_buf_d = buf_kept | (PISO_BUF_W'(word_data_i) << fill_kept);
      fill_d    = fill_kept + PISO_FILL_W'(WORD_W);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      bit_buf_q <= '0;
      fill_q    <= '0;
    end else if (flush_i) begin
      bit_buf_q <= '0;
      fill_q    <= '0;
    end else begin
      bit_buf_q <= bit_buf_d;
      fill_q    <= fill_d;
    end
  end

endmodule

/* hw/rej_sampler.sv */
// --------------------------------------------------------------------------
// rejection sampler for ML-DSA (4 x 24-bit) and ML-KEM (8 x 12-bit)
// accepted values queue in order, four leave per strobe, lane 0 oldest
// slices are refused while the queue could not take a full slice
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module rej_sampler (
  input  logic                                clk,
  input  logic                                rst_b,
  input  sampler_pkg::sampler_mode_e          mode_i,
  input  logic                                flush_i,
  input  logic                                slice_valid_i,
  input  logic [sampler_pkg::REJ_SLICE_W-1:0] slice_data_i,
  output logic                                hold_o,
  output logic                                ntt_dv_o,
  output sampler_pkg::coeff_group_t           ntt_data_o
);

  import sampler_pkg::*;

  logic [COEFF_W-1:0]                     queue_q [REJ_QUEUE_DEPTH];
  logic [COEFF_W-1:0]                     queue_d [REJ_QUEUE_DEPTH];
  logic [REJ_CNT_W-1:0]                   cnt_q;
  logic [REJ_CNT_W-1:0]                   cnt_d;
  logic [REJ_CNT_W-1:0]                   wr_idx;
  logic [REJ_CNT_W-1:0]                   cand_cnt;
  logic [MLKEM_CAND_CNT-1:0][COEFF_W-1:0] cand;
  logic [MLKEM_CAND_CNT-1:0]              cand_ok;
  logic                                   rej_mode;
  logic                                   slice_take;
  logic                                   pop;

  assign rej_mode = (mode_i == MODE_MLDSA_REJ) || (mode_i == MODE_MLKEM_REJ);
  assign cand_cnt = (mode_i == MODE_MLKEM_REJ) ? REJ_CNT_W'(MLKEM_CAND_CNT) :
                                                 REJ_CNT_W'(MLDSA_CAND_CNT);

  assign hold_o     = (REJ_CNT_W'(REJ_QUEUE_DEPTH) - cnt_q) < cand_cnt;
  assign slice_take = rej_mode && slice_valid_i && !hold_o;
  assign pop        = (cnt_q >= REJ_CNT_W'(COEFF_PER_CLK));

  // split slice into candidates, lowest lane first
  always_comb begin
    cand    = '0;
    cand_ok = '0;
    if (mode_i == MODE_MLDSA_REJ) begin
      for (int i = 0; i < MLDSA_CAND_CNT; i++) begin
        // top bit of the 24-bit candidate dropped
        cand[i]    = slice_data_i[i*MLDSA_CAND_W +: COEFF_W];
        cand_ok[i] = (cand[i] < COEFF_W'(MLDSA_Q));
      end
    end else begin
      for (int i = 0; i < MLKEM_CAND_CNT; i++) begin
        cand[i]    = COEFF_W'(slice_data_i[i*MLKEM_CAND_W +: MLKEM_CAND_W]);
        cand_ok[i] = (cand[i] < COEFF_W'(MLKEM_Q));
      end
    end
  end

  // pop four from the bottom, then pack accepted values above the rest
  always_comb begin
    queue_d = queue_q;
    cnt_d   = cnt_q;
    if (pop) begin
      for (int i = 0; i < REJ_QUEUE_DEPTH - COEFF_PER_CLK; i++) begin
        queue_d[i] = queue_q[i+COEFF_PER_CLK];
      end
      cnt_d = cnt_q - REJ_CNT_W'(COEFF_PER_CLK);
    end
    wr_idx = cnt_d;
    if (slice_take) begin
      for (int i = 0; i < MLKEM_CAND_CNT; i++) begin
        if (cand_ok[i]) begin
          queue_d[wr_idx] = cand[i];
          wr_idx          = wr_idx + 1'b1;
        end
      end
    end
    cnt_d = wr_idx;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q    <= '0;
      ntt_dv_o <= 1'b0;
    end else if (flush_i) begin
      cnt_q    <= '0;
      ntt_dv_o <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      ntt_dv_o <= pop;
    end
  end

  always_ff @(posedge clk) begin
    queue_q <= queue_d;
    if (pop) begin
      for (int i = 0; i < COEFF_PER_CLK; i++) begin
        ntt_data_o[i] <= queue_q[i];
      end
    end
  end

endmodule

/* hw/exp_mask.sv */
// --------------------------------------------------------------------------
// mask expansion, four 20-bit values x per slice become (2^19 - x) mod q
// one cycle from slice to memory strobe, every slice is accepted
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module exp_mask (
  input  logic                                clk,
  input  logic                                rst_b,
  input  sampler_pkg::sampler_mode_e          mode_i,
  input  logic                                flush_i,
  input  logic                                slice_valid_i,
  input  logic [sampler_pkg::EXP_SLICE_W-1:0] slice_data_i,
  output logic                                mem_dv_o,
  output sampler_pkg::coeff_group_t           mem_data_o
);

  import sampler_pkg::*;

  logic [COEFF_W-1:0] x [COEFF_PER_CLK];
  coeff_group_t       coeff;
  logic               slice_take;

  assign slice_take = slice_valid_i && (mode_i == MODE_EXP_MASK);

  always_comb begin
    for (int i = 0; i < COEFF_PER_CLK; i++) begin
      x[i] = COEFF_W'(slice_data_i[i*EXP_SAMPLE_W +: EXP_SAMPLE_W]);
      // negative result wraps by adding q
      if (x[i] > COEFF_W'(EXP_GAMMA1)) begin
        coeff[i] = COEFF_W'(MLDSA_Q) - (x[i] - COEFF_W'(EXP_GAMMA1));
      end else begin
        coeff[i] = COEFF_W'(EXP_GAMMA1) - x[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      mem_dv_o <= 1'b0;
    end else if (flush_i) begin
      mem_dv_o <= 1'b0;
    end else begin
      mem_dv_o <= slice_take;
    end
  end

  always_ff @(posedge clk) begin
    if (slice_take) begin
      mem_data_o <= coeff;
    end
  end

endmodule

/* hw/sampler_top.sv */
// --------------------------------------------------------------------------
// coefficient sampler top, random words in, 256 coefficients per job out
// outputs take no back-pressure, mode and base address stay stable while busy
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module sampler_top (
  input  logic                           clk,
  input  logic                           rst_b,
  input  logic                           zeroize_i,
  input  sampler_pkg::sampler_mode_e     mode_i,
  input  logic                           start_i,
  input  logic [sampler_pkg::ADDR_W-1:0] dest_base_addr_i,
  output logic                           busy_o,
  input  logic                           word_valid_i,
  input  logic [sampler_pkg::WORD_W-1:0] word_data_i,
  output logic                           word_hold_o,
  output logic                           ntt_dv_o,
  output sampler_pkg::coeff_group_t      ntt_data_o,
  output logic                           mem_dv_o,
  output sampler_pkg::coeff_group_t      mem_data_o,
  output logic [sampler_pkg::ADDR_W-1:0] mem_addr_o
);

  import sampler_pkg::*;

  logic                   run;
  logic                   flush;
  logic                   slice_valid;
  logic                   rej_hold;
  logic [REJ_SLICE_W-1:0] slice_data;

  sampler_ctrl u_ctrl (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize_i),
    .start_i          (start_i),
    .dest_base_addr_i (dest_base_addr_i),
    .ntt_dv_i         (ntt_dv_o),
    .mem_dv_i         (mem_dv_o),
    .run_o            (run),
    .flush_o          (flush),
    .busy_o           (busy_o),
    .mem_addr_o       (mem_addr_o)
  );

  sample_piso u_piso (
    .clk           (clk),
    .rst_b         (rst_b),
    .mode_i        (mode_i),
    .run_i         (run),
    .flush_i       (flush),
    .word_valid_i  (word_valid_i),
    .word_data_i   (word_data_i),
    .hold_i        (rej_hold),
    .word_hold_o   (word_hold_o),
    .slice_valid_o (slice_valid),
    .slice_data_o  (slice_data)
  );

  rej_sampler u_rej (
    .clk           (clk),
    .rst_b         (rst_b),
    .mode_i        (mode_i),
    .flush_i       (flush),
    .slice_valid_i (slice_valid),
    .slice_data_i  (slice_data),
    .hold_o        (rej_hold),
    .ntt_dv_o      (ntt_dv_o),
    .ntt_data_o    (ntt_data_o)
  );

  // mask mode uses the low 80 bits of the slice
  exp_mask u_exp (
    .clk           (clk),
    .rst_b         (rst_b),
    .mode_i        (mode_i),
    .flush_i       (flush),
    .slice_valid_i (slice_valid),
    .slice_data_i  (slice_data[EXP_SLICE_W-1:0]),
    .mem_dv_o      (mem_dv_o),
    .mem_data_o    (mem_data_o)
  );

endmodule

/* bench/sampler_sva.sv */
// --------------------------------------------------------------------------
// checks bound to the sampler top level, strobes and word hold vs busy
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module sampler_sva (
  input logic clk,
  input logic rst_b,
  input logic busy_i,
  input logic word_hold_i,
  input logic ntt_dv_i,
  input logic mem_dv_i
);

  int fail_cnt = 0;

  // a job drives one output port only
  one_port_a: assert property (@(posedge clk) disable iff (!rst_b) !(ntt_dv_i && mem_dv_i))
    else begin
      fail_cnt++;
      $error("NTT and memory strobes high in the same cycle");
    end

  hold_idle_a: assert property (@(posedge clk) disable iff (!rst_b) !busy_i |-> word_hold_i)
    else begin
      fail_cnt++;
      $error("word_hold_o low while idle");
    end

  strobe_busy_a: assert property (@(posedge clk) disable iff (!rst_b)
                                  (ntt_dv_i || mem_dv_i) |-> busy_i)
    else begin
      fail_cnt++;
      $error("output strobe while not busy");
    end

endmodule

bind sampler_top sampler_sva u_sva (
  .clk         (clk),
  .rst_b       (rst_b),
  .busy_i      (busy_o),
  .word_hold_i (word_hold_o),
  .ntt_dv_i    (ntt_dv_o),
  .mem_dv_i    (mem_dv_o)
);

/* bench/sampler_model.svh */
// --------------------------------------------------------------------------
// bit stream model of the sampler, expects sampler_pkg imported by the bench
// words are appended LSB-first, a job starts from an empty stream
// --------------------------------------------------------------------------

`ifndef SAMPLER_MODEL_SVH
`define SAMPLER_MODEL_SVH

  bit                 stream_bits[$];
  logic [COEFF_W-1:0] coeff_fifo[$];

  function automatic void clear_stream();
    stream_bits.delete();
    coeff_fifo.delete();
  endfunction

  function automatic void append_word(input logic [WORD_W-1:0] word);
    for (int i = 0; i < WORD_W; i++) begin
      stream_bits.push_back(word[i]);
    end
  endfunction

  function automatic logic [31:0] pop_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value[i] = stream_bits.pop_front();
    end
    return value;
  endfunction

  // one slice worth of candidates or mask values
  function automatic void sample_slice(input sampler_mode_e mode);
    logic [31:0] x;
    int          diff;
    if (mode == MODE_MLDSA_REJ) begin
      for (int i = 0; i < REJ_SLICE_W / MLDSA_CAND_W; i++) begin
        x = pop_bits(MLDSA_CAND_W);
        x[MLDSA_CAND_W-1] = 1'b0;
        if (x < MLDSA_Q) coeff_fifo.push_back(x[COEFF_W-1:0]);
      end
    end else if (mode == MODE_MLKEM_REJ) begin
      for (int i = 0; i < REJ_SLICE_W / MLKEM_CAND_W; i++) begin
        x = pop_bits(MLKEM_CAND_W);
        if (x < MLKEM_Q) coeff_fifo.push_back(x[COEFF_W-1:0]);
      end
    end else begin
      for (int i = 0; i < EXP_SLICE_W / EXP_SAMPLE_W; i++) begin
        x    = pop_bits(EXP_SAMPLE_W);
        diff = int'(EXP_GAMMA1) - int'(x);
        if (diff < 0) diff = diff + int'(MLDSA_Q);
        coeff_fifo.push_back(diff[COEFF_W-1:0]);
      end
    end
  endfunction

  // returns 0 when the stream holds too few bits for a full group
  function automatic bit next_group(input sampler_mode_e mode, output coeff_group_t group);
    int slice_w;
    slice_w = (mode == MODE_EXP_MASK) ? EXP_SLICE_W : REJ_SLICE_W;
    group   = '0;
    while (coeff_fifo.size() < COEFF_PER_CLK && stream_bits.size() >= slice_w) begin
      sample_slice(mode);
    end
    if (coeff_fifo.size() < COEFF_PER_CLK) return 1'b0;
    for (int i = 0; i < COEFF_PER_CLK; i++) begin
      group[i] = coeff_fifo.pop_front();
    end
    return 1'b1;
  endfunction

`endif

/* bench/sampler_tb.sv */
// --------------------------------------------------------------------------
// random words with random valid gaps over eight jobs
// inputs change and strobes are checked on the falling edge
// --------------------------------------------------------------------------

`timescale 1ns/10ps

module sampler_tb;

  import sampler_pkg::*;

  localparam int unsigned SEED        = 32'h449f5664;
  localparam int          JOB_CNT     = 8;
  localparam int          JOB_CYCLES  = 2000;
  localparam int          IDLE_CYCLES = 4;

  logic              clk;
  logic              rst_b;
  logic              zeroize_i;
  sampler_mode_e     mode_i;
  logic              start_i;
  logic [ADDR_W-1:0] dest_base_addr_i;
  logic              busy_o;
  logic              word_valid_i;
  logic [WORD_W-1:0] word_data_i;
  logic              word_hold_o;
  logic              ntt_dv_o;
  coeff_group_t      ntt_data_o;
  logic              mem_dv_o;
  coeff_group_t      mem_data_o;
  logic [ADDR_W-1:0] mem_addr_o;
  bit                word_held;
  int                error_cnt;
  int                check_cnt;
  int                total_err;

  `include "sampler_model.svh"

  sampler_top uut (.*);

  always #4 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [127:0] exp, act);
    error_cnt++;
    $display("[FAIL] %0d ns: %s expected %h, got %h", $time, name, exp, act);
  endtask

  task automatic report_problem(input string msg);
    error_cnt++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  // a held word stays on the bus until taken
  task automatic drive_word();
    if (!word_held) begin
      word_valid_i = ($urandom % 4) != 0;
      word_data_i  = {$urandom, $urandom};
    end
    word_held = word_valid_i && word_hold_o;
    if (word_valid_i && !word_hold_o) append_word(word_data_i);
  endtask

  task automatic check_strobe(input sampler_mode_e mode, input logic [ADDR_W-1:0] base,
                              input int idx);
    coeff_group_t exp_group;
    bit           have;
    int unsigned  q;
    have = next_group(mode, exp_group);
    q    = (mode == MODE_MLKEM_REJ) ? MLKEM_Q : MLDSA_Q;
    check_cnt++;
    assert (have) else report_problem($sformatf("strobe %0d before enough words", idx));
    if (mode == MODE_EXP_MASK) begin
      assert (!ntt_dv_o) else report_problem("NTT strobe during a mask job");
      assert (mem_data_o == exp_group) else report_mismatch("mem_data_o", exp_group, mem_data_o);
      assert (mem_addr_o == ADDR_W'(base + idx))
        else report_mismatch("mem_addr_o", ADDR_W'(base + idx), mem_addr_o);
    end else begin
      assert (!mem_dv_o) else report_problem("memory strobe during a rejection job");
      assert (ntt_data_o == exp_group) else report_mismatch("ntt_data_o", exp_group, ntt_data_o);
      for (int i = 0; i < COEFF_PER_CLK; i++) begin
        assert (ntt_data_o[i] < q) else report_problem("NTT coefficient not below q");
      end
    end
  endtask

  // zero_after < 0 runs the job to its end
  task automatic run_job(input sampler_mode_e mode, input int zero_after);
    logic [ADDR_W-1:0] base;
    int                strobes;
    int                cycles;
    bit                ended;
    base    = ADDR_W'($urandom);
    strobes = 0;
    cycles  = 0;
    ended   = 1'b0;
    clear_stream();
    @(negedge clk);
    mode_i           = mode;
    dest_base_addr_i = base;
    start_i          = 1'b1;
    #1;
    assert (busy_o) else report_problem("busy_o low in the start cycle");
    while (!ended && cycles < JOB_CYCLES) begin
      @(negedge clk);
      start_i = 1'b0;
      cycles++;
      if (ntt_dv_o || mem_dv_o) begin
        check_strobe(mode, base, strobes);
        strobes++;
      end
      if (strobes == GROUP_CNT) begin
        ended = 1'b1;
      end else if (strobes == zero_after) begin
        zeroize_i = 1'b1;
        ended     = 1'b1;
      end
      if (ended) begin
        word_valid_i = 1'b0;
        word_held    = 1'b0;
      end else begin
        drive_word();
      end
    end
    assert (ended)
      else report_problem($sformatf("%s job stalled at %0d strobes", mode.name(), strobes));
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      zeroize_i = 1'b0;
      assert (!busy_o) else report_problem("busy_o still high after the job ended");
      assert (!ntt_dv_o && !mem_dv_o) else report_problem("strobe after the job ended");
    end
  endtask

  initial begin
    clk              = 1'b0;
    rst_b            = 1'b0;
    zeroize_i        = 1'b0;
    mode_i           = MODE_MLDSA_REJ;
    start_i          = 1'b0;
    dest_base_addr_i = '0;
    word_valid_i     = 1'b0;
    word_data_i      = '0;
    word_held        = 1'b0;
    error_cnt        = 0;
    check_cnt        = 0;
    void'($urandom(SEED));
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
    assert (!busy_o && word_hold_o && !ntt_dv_o && !mem_dv_o)
      else report_problem("outputs active after reset");
    run_job(MODE_MLDSA_REJ, -1);
    run_job(MODE_MLKEM_REJ, -1);
    run_job(MODE_EXP_MASK, -1);
    run_job(MODE_MLKEM_REJ, 23);
    run_job(MODE_EXP_MASK, -1);
    run_job(MODE_MLDSA_REJ, 41);
    run_job(MODE_EXP_MASK, 17);
    run_job(MODE_MLKEM_REJ, -1);
    total_err = error_cnt + uut.u_sva.fail_cnt;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             check_cnt, error_cnt, uut.u_sva.fail_cnt);
    if (total_err == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (JOB_CNT * JOB_CYCLES) @(posedge clk);
    $display("timeout: run not finished after %0d cycles", JOB_CNT * JOB_CYCLES);
    $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sampler_top.f */
+incdir+bench
hw/sampler_pkg.sv
hw/sampler_ctrl.sv
hw/sample_piso.sv
hw/rej_sampler.sv
hw/exp_mask.sv
hw/sampler_top.sv
bench/sampler_sva.sv
bench/sampler_tb.sv

/* Makefile */
TOOL    := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := sampler_tb
FLIST   := sampler_top.f
OBJ_DIR := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(TOOL) --lint-only --timing -Wall -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
